// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_spi_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: apb_spi_regs.sv
// APB register block for the SPI master
`timescale 1ns/10ps
`default_nettype none

module apb_spi_regs (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [spi_pkg::APB_AW-1:0]         paddr,
    input  logic [spi_pkg::APB_DW-1:0]         pwdata,
    output logic [spi_pkg::APB_DW-1:0]         prdata,
    output logic                               pready,
    output logic                               pslverr,

    output logic                               cmd_push,
    output spi_pkg::spi_cmd_t                  cmd_data,
    input  logic                               cmd_full,
    input  logic                               cmd_empty,

    output logic                               rx_pop,
    input  spi_pkg::spi_rx_t                   rx_data,
    input  logic                               rx_full,
    input  logic                               rx_empty,

    input  logic                               busy
);

    localparam int CMD_W = $bits(spi_pkg::spi_cmd_t);
    localparam int RX_W  = $bits(spi_pkg::spi_rx_t);

    logic                       access;
    logic                       hit_txcmd;
    logic                       hit_rxdata;
    logic                       hit_status;
    logic                       wr_txcmd;
    logic                       rd_rxdata;
    logic                       rd_status;
    logic [spi_pkg::APB_DW-1:0] status_word;

    assign access = psel && penable;    // Access phase, always a single cycle.

    assign hit_txcmd  = (paddr == spi_pkg::REG_TXCMD);
    assign hit_rxdata = (paddr == spi_pkg::REG_RXDATA);
    assign hit_status = (paddr == spi_pkg::REG_STATUS);

    assign wr_txcmd  = access && pwrite && hit_txcmd;
    assign rd_rxdata = access && !pwrite && hit_rxdata;
    assign rd_status = access && !pwrite && hit_status;

    // A full command FIFO drops the write.
    assign cmd_push = wr_txcmd && !cmd_full;
    assign cmd_data = spi_pkg::spi_cmd_t'(pwdata[CMD_W-1:0]);

    assign rx_pop = rd_rxdata && !rx_empty;

    assign pready = 1'b1;

    // Anything that is not one of the three legal accesses is an error.
    assign pslverr = access && !(cmd_push || rx_pop || rd_status);

    always_comb begin
        status_word                        = '0;
        status_word[spi_pkg::ST_CMD_FULL]  = cmd_full;
        status_word[spi_pkg::ST_CMD_EMPTY] = cmd_empty;
        status_word[spi_pkg::ST_RX_FULL]   = rx_full;
        status_word[spi_pkg::ST_RX_EMPTY]  = rx_empty;
        status_word[spi_pkg::ST_BUSY]      = busy;
    end

    always_comb begin
        prdata = '0;
        if (rx_pop) begin
            prdata = {{(spi_pkg::APB_DW - RX_W){1'b0}}, rx_data};
        end else if (rd_status) begin
            prdata = status_word;
        end
    end

endmodule

`default_nettype wire

// File: project.f
spi_pkg.sv
spi_fifo.sv
apb_spi_regs.sv
spi_master_engine.sv
spi_master_top.sv
tb_spi_checker.sv
tb_spi_top.sv

// File: spi_fifo.sv
// Synchronous FIFO with typed payload
`timescale 1ns/10ps
`default_nettype none

module spi_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  T                       wdata,
    input  logic                   pop,
    output T                       rdata,
    output logic                   full,
    output logic                   empty,
    output logic [$clog2(DEPTH):0] count
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;
    logic [CW-1:0] count_next;

    assign do_push = push && !full;    // Overflow is dropped.
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rd_ptr];      // Head is always visible.

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Power of two depth wraps on its own.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == CW'(DEPTH));
            empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: spi_master_engine.sv
// SPI mode 0 transfer engine
`timescale 1ns/10ps
`default_nettype none

module spi_master_engine #(
    parameter int CLK_DIV = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  spi_pkg::spi_cmd_t               cmd,
    input  logic                            cmd_empty,
    output logic                            cmd_pop,

    output logic                            rx_push,
    output spi_pkg::spi_rx_t                rx_word,
    input  logic                            rx_full,

    output logic                            busy,

    output logic                            sclk,
    output logic [spi_pkg::SLAVE_COUNT-1:0] cs_n,
    output logic                            mosi,
    input  logic [spi_pkg::SLAVE_COUNT-1:0] miso
);

    localparam int DIV_W = $clog2(CLK_DIV + 1);
    localparam int CNT_W = $clog2(spi_pkg::DATA_W);
    localparam logic [spi_pkg::SLAVE_COUNT-1:0] CS_ONE = 1;

    logic [DIV_W-1:0]          div_cnt;
    logic [CNT_W-1:0]          bit_cnt;
    logic [spi_pkg::SEL_W-1:0] sel_q;
    logic [spi_pkg::DATA_W-1:0] shreg;
    logic                      start;
    logic                      half_done;
    logic                      last_bit;

    // Hold off while the previous result is still being written.
    assign start     = !busy && !rx_push && !cmd_empty && !rx_full;
    assign cmd_pop   = start;
    assign half_done = busy && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_bit  = (bit_cnt == CNT_W'(spi_pkg::DATA_W - 1));

    assign rx_word.sel = sel_q;
    assign rx_word.rx  = shreg;    // Stable until the next pop.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            sclk    <= 1'b0;
            cs_n    <= '1;
            mosi    <= 1'b0;
            rx_push <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            rx_push <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                sclk    <= 1'b0;
                cs_n    <= ~(CS_ONE << cmd.sel);
                mosi    <= cmd.tx[spi_pkg::DATA_W-1];    // MSB is out before the first edge.
                div_cnt <= '0;
                bit_cnt <= '0;
            end else if (busy) begin
                if (half_done) begin
                    div_cnt <= '0;
                    if (!sclk) begin
                        sclk <= 1'b1;
                    end else begin
                        sclk <= 1'b0;
                        if (last_bit) begin
                            busy    <= 1'b0;
                            cs_n    <= '1;
                            mosi    <= 1'b0;
                            rx_push <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            mosi    <= shreg[spi_pkg::DATA_W-1];    // Next bit on the falling edge.
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    // Transmit bits leave at the top while received bits enter at the bottom.
    always_ff @(posedge clk) begin
        if (start) begin
            sel_q <= cmd.sel;
            shreg <= cmd.tx;
        end else if (half_done && !sclk) begin
            shreg <= {shreg[spi_pkg::DATA_W-2:0], miso[sel_q]};
        end
    end

endmodule

`default_nettype wire

// File: spi_master_top.sv
// SPI master subsystem top level
`timescale 1ns/10ps
`default_nettype none

module spi_master_top #(
    parameter int CLK_DIV   = 2,
    parameter int CMD_DEPTH = 4,
    parameter int RX_DEPTH  = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [spi_pkg::APB_AW-1:0]      paddr,
    input  logic [spi_pkg::APB_DW-1:0]      pwdata,
    output logic [spi_pkg::APB_DW-1:0]      prdata,
    output logic                            pready,
    output logic                            pslverr,

    output logic                            sclk,
    output logic [spi_pkg::SLAVE_COUNT-1:0] cs_n,
    output logic                            mosi,
    input  logic [spi_pkg::SLAVE_COUNT-1:0] miso
);

    logic              cmd_push;
    logic              cmd_pop;
    logic              cmd_full;
    logic              cmd_empty;
    spi_pkg::spi_cmd_t cmd_wdata;
    spi_pkg::spi_cmd_t cmd_rdata;
    logic              rx_push;
    logic              rx_pop;
    logic              rx_full;
    logic              rx_empty;
    spi_pkg::spi_rx_t  rx_wdata;
    spi_pkg::spi_rx_t  rx_rdata;
    logic              busy;

    apb_spi_regs i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd_push  (cmd_push),
        .cmd_data  (cmd_wdata),
        .cmd_full  (cmd_full),
        .cmd_empty (cmd_empty),
        .rx_pop    (rx_pop),
        .rx_data   (rx_rdata),
        .rx_full   (rx_full),
        .rx_empty  (rx_empty),
        .busy      (busy)
    );

    spi_fifo #(
        .T     (spi_pkg::spi_cmd_t),
        .DEPTH (CMD_DEPTH)
    ) cmd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (cmd_push),
        .wdata (cmd_wdata),
        .pop   (cmd_pop),
        .rdata (cmd_rdata),
        .full  (cmd_full),
        .empty (cmd_empty),
        .count ()
    );

    spi_fifo #(
        .T     (spi_pkg::spi_rx_t),
        .DEPTH (RX_DEPTH)
    ) rx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rx_push),
        .wdata (rx_wdata),
        .pop   (rx_pop),
        .rdata (rx_rdata),
        .full  (rx_full),
        .empty (rx_empty),
        .count ()
    );

    spi_master_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd_rdata),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .rx_push   (rx_push),
        .rx_word   (rx_wdata),
        .rx_full   (rx_full),
        .busy      (busy),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso)
    );

endmodule

`default_nettype wire

// File: spi_pkg.sv
// SPI master shared definitions
`default_nettype none

package spi_pkg;

    // SPI word and slave select sizing.
    localparam int DATA_W      = 8;
    localparam int SLAVE_COUNT = 4;
    localparam int SEL_W       = $clog2(SLAVE_COUNT);

    // APB bus sizing.
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // One queued transfer request.
    typedef struct packed {
        logic [SEL_W-1:0]  sel;    // Target slave index.
        logic [DATA_W-1:0] tx;     // Word shifted out on mosi.
    } spi_cmd_t;

    // One completed transfer result.
    typedef struct packed {
        logic [SEL_W-1:0]  sel;    // Slave the word came from.
        logic [DATA_W-1:0] rx;     // Word shifted in from miso.
    } spi_rx_t;

    // Register map offsets.
    localparam logic [APB_AW-1:0] REG_TXCMD  = 4'h0;    // Write only.
    localparam logic [APB_AW-1:0] REG_RXDATA = 4'h4;    // Read pops the receive FIFO.
    localparam logic [APB_AW-1:0] REG_STATUS = 4'h8;    // Read only.

    // Bit positions inside the status register.
    localparam int ST_CMD_FULL  = 0;
    localparam int ST_CMD_EMPTY = 1;
    localparam int ST_RX_FULL   = 2;
    localparam int ST_RX_EMPTY  = 3;
    localparam int ST_BUSY      = 4;

endpackage

`default_nettype wire

// File: tb_spi_checker.sv
// SPI master scoreboard
`timescale 1ns/10ps
`default_nettype none

module tb_spi_checker #(
    parameter int CLK_DIV   = 2,
    parameter int CMD_DEPTH = 4,
    parameter int RX_DEPTH  = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [spi_pkg::APB_AW-1:0]      paddr,
    input  logic [spi_pkg::APB_DW-1:0]      pwdata,
    input  logic [spi_pkg::APB_DW-1:0]      prdata,
    input  logic                            pready,
    input  logic                            pslverr,
    input  logic                            sclk,
    input  logic [spi_pkg::SLAVE_COUNT-1:0] cs_n,
    input  logic                            mosi,
    output int                              mismatch_count,
    output int                              other_count,
    output int                              outstanding
);

    localparam int CMD_W    = $bits(spi_pkg::spi_cmd_t);
    localparam int RX_W     = $bits(spi_pkg::spi_rx_t);
    localparam int XFER_LOW = 2 * CLK_DIV * spi_pkg::DATA_W;    // Cycles with cs_n low.
    localparam logic [spi_pkg::SLAVE_COUNT-1:0] CS_ONE = 1;

    logic [spi_pkg::DATA_W-1:0] last_word [spi_pkg::SLAVE_COUNT];
    spi_pkg::spi_rx_t           expect_q [$];
    logic [spi_pkg::SEL_W-1:0]  sel_q [$];
    int                         mismatches = 0;
    int                         others = 0;
    int                         pending = 0;
    int                         cmd_occ;     // Commands waiting in the command FIFO.
    int                         rx_avail;    // Words visible in the receive FIFO.
    int                         low_cycles;
    int                         sclk_rises;
    logic                       end_pending;
    logic [spi_pkg::SEL_W-1:0]  cur_sel;
    logic                       cs_flagged;
    logic                       sclk_prev;
    logic [spi_pkg::SLAVE_COUNT-1:0] cs_prev;

    assign mismatch_count = mismatches;
    assign other_count    = others;
    assign outstanding    = pending;

    // A slave hands back the word it received last.
    function automatic spi_pkg::spi_rx_t expected_rx(input logic [spi_pkg::SEL_W-1:0] slave,
                                                     input logic [spi_pkg::DATA_W-1:0] tx);
        spi_pkg::spi_rx_t r;
        r.sel            = slave;
        r.rx             = last_word[slave];
        last_word[slave] = tx;
        return r;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatches++;
        $display("MISMATCH at %0t: %s read 0x%h, expected 0x%h", $time, what, got, exp);
    endtask

    task automatic check_access();
        logic              exp_err;
        logic [31:0]       exp_word;
        spi_pkg::spi_cmd_t cmd;
        spi_pkg::spi_rx_t  head;
        exp_err  = 1'b1;    // Unknown offsets and wrong directions are errors.
        exp_word = '0;
        if (pwrite && paddr == spi_pkg::REG_TXCMD) begin
            exp_err = (cmd_occ >= CMD_DEPTH);
        end else if (!pwrite && paddr == spi_pkg::REG_RXDATA) begin
            exp_err = (rx_avail == 0);
        end else if (!pwrite && paddr == spi_pkg::REG_STATUS) begin
            exp_err = 1'b0;
        end
        if (pready !== 1'b1) begin
            others++;
            $display("%0t: pready was low during an access phase", $time);
        end
        if (pslverr !== exp_err) begin
            others++;
            $display("%0t: pslverr is %b on access to offset 0x%h (write %b), should be %b",
                     $time, pslverr, paddr, pwrite, exp_err);
        end
        if (pwrite && paddr == spi_pkg::REG_TXCMD && !pslverr) begin
            cmd = spi_pkg::spi_cmd_t'(pwdata[CMD_W-1:0]);
            expect_q.push_back(expected_rx(cmd.sel, cmd.tx));
            sel_q.push_back(cmd.sel);
            cmd_occ++;
        end else if (!pwrite && paddr == spi_pkg::REG_RXDATA) begin
            if (pslverr) begin
                if (prdata !== '0) report_mismatch("RXDATA on empty FIFO", prdata, '0);
            end else if (expect_q.size() == 0) begin
                others++;
                $display("%0t: RXDATA returned a word with no transfer outstanding", $time);
            end else begin
                head                 = expect_q.pop_front();
                exp_word[RX_W-1:0]   = head;
                rx_avail--;
                if (prdata !== exp_word) report_mismatch("RXDATA", prdata, exp_word);
            end
        end else if (!pwrite && paddr == spi_pkg::REG_STATUS) begin
            exp_word[spi_pkg::ST_CMD_FULL]  = (cmd_occ >= CMD_DEPTH);
            exp_word[spi_pkg::ST_CMD_EMPTY] = (cmd_occ == 0);
            exp_word[spi_pkg::ST_RX_FULL]   = (rx_avail >= RX_DEPTH);
            exp_word[spi_pkg::ST_RX_EMPTY]  = (rx_avail == 0);
            exp_word[spi_pkg::ST_BUSY]      = (cs_n != '1);
            if (prdata !== exp_word) report_mismatch("STATUS", prdata, exp_word);
        end
    endtask

    // Everything is sampled mid-cycle, well away from both clock edges.
    always @(negedge clk) begin
        if (!rst_n) begin
            if (cs_n !== '1 || sclk !== 1'b0 || mosi !== 1'b0 || pslverr !== 1'b0) begin
                others++;
                $display("%0t: SPI pins or pslverr not at their reset values", $time);
            end
            for (int s = 0; s < spi_pkg::SLAVE_COUNT; s++) begin
                last_word[s] = spi_pkg::DATA_W'(8'hA0 + s);
            end
            expect_q.delete();
            sel_q.delete();
            cmd_occ     = 0;
            rx_avail    = 0;
            low_cycles  = 0;
            sclk_rises  = 0;
            end_pending = 1'b0;
            cs_prev     = '1;
            cs_flagged  = 1'b0;
            sclk_prev   = 1'b0;
        end else begin
            if (end_pending) rx_avail++;    // The pushed word shows one cycle after cs_n rises.
            end_pending = 1'b0;
            if (cs_prev == '1 && cs_n != '1) begin
                cs_flagged = 1'b0;
                low_cycles = 0;
                sclk_rises = 0;
                if (sel_q.size() == 0) begin
                    others++;
                    $display("%0t: a transfer started with no accepted command", $time);
                end else begin
                    cur_sel = sel_q.pop_front();
                    cmd_occ--;
                end
            end else if (cs_prev != '1 && cs_n == '1) begin
                end_pending = 1'b1;
                if (low_cycles != XFER_LOW || sclk_rises != spi_pkg::DATA_W) begin
                    others++;
                    $display("%0t: cs_n was low %0d cycles with %0d sclk rises, not %0d and %0d",
                             $time, low_cycles, sclk_rises, XFER_LOW, spi_pkg::DATA_W);
                end
            end
            if (cs_n != '1) begin
                low_cycles++;
                if (sclk && !sclk_prev) sclk_rises++;
            end else if (sclk !== 1'b0) begin
                others++;
                $display("%0t: sclk is high while no chip select is low", $time);
            end
            if (cs_n != '1 && !cs_flagged) begin
                if ($countones(~cs_n) > 1) begin
                    others++;
                    cs_flagged = 1'b1;
                    $display("%0t: more than one chip select low, cs_n = %b", $time, cs_n);
                end else if (cs_n != ~(CS_ONE << cur_sel)) begin
                    others++;
                    cs_flagged = 1'b1;
                    $display("%0t: cs_n = %b does not select slave %0d", $time, cs_n, cur_sel);
                end
            end
            cs_prev   = cs_n;
            sclk_prev = sclk;
            if (psel && penable) check_access();
            pending = expect_q.size();
        end
    end

endmodule

`default_nettype wire

// File: tb_spi_top.sv
// SPI master subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module tb_spi_top;

    localparam int CLK_DIV     = 2;
    localparam int CMD_DEPTH   = 4;
    localparam int RX_DEPTH    = 4;
    localparam int SEED        = 70695;
    localparam int NUM_CMDS    = 58;
    localparam int XFER_CYCLES = 2 * CLK_DIV * spi_pkg::DATA_W + 1;
    localparam int APB_CYCLES  = 100;
    localparam int MAX_CYCLES  = 2 * (NUM_CMDS * XFER_CYCLES + APB_CYCLES);
    localparam int CMD_W       = $bits(spi_pkg::spi_cmd_t);

    logic                            clk;
    logic                            rst_n;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [spi_pkg::APB_AW-1:0]      paddr;
    logic [spi_pkg::APB_DW-1:0]      pwdata;
    logic [spi_pkg::APB_DW-1:0]      prdata;
    logic                            pready;
    logic                            pslverr;
    logic                            sclk;
    logic [spi_pkg::SLAVE_COUNT-1:0] cs_n;
    logic                            mosi;
    wire  [spi_pkg::SLAVE_COUNT-1:0] miso;
    int                              mismatch_count;
    int                              other_count;
    int                              outstanding;
    int                              cycles;

    spi_master_top #(
        .CLK_DIV   (CLK_DIV),
        .CMD_DEPTH (CMD_DEPTH),
        .RX_DEPTH  (RX_DEPTH)
    ) i_dut (
        .clk (clk), .rst_n (rst_n),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .sclk (sclk), .cs_n (cs_n), .mosi (mosi), .miso (miso)
    );

    tb_spi_checker #(
        .CLK_DIV   (CLK_DIV),
        .CMD_DEPTH (CMD_DEPTH),
        .RX_DEPTH  (RX_DEPTH)
    ) i_checker (
        .clk (clk), .rst_n (rst_n),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .sclk (sclk), .cs_n (cs_n), .mosi (mosi),
        .mismatch_count (mismatch_count), .other_count (other_count),
        .outstanding (outstanding)
    );

    // Mode 0 slaves that echo the previous word.
    for (genvar s = 0; s < spi_pkg::SLAVE_COUNT; s++) begin : g_slave
        logic [spi_pkg::DATA_W-1:0] sr = spi_pkg::DATA_W'(8'hA0 + s);
        logic                       out_bit = 1'b0;

        assign miso[s] = out_bit;

        always @(posedge sclk) begin
            if (!cs_n[s]) sr <= {sr[spi_pkg::DATA_W-2:0], mosi};
        end

        always @(negedge sclk or negedge cs_n[s]) begin
            if (!cs_n[s]) out_bit <= sr[spi_pkg::DATA_W-1];
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Callers start every access 1 ns after a rising edge.
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [31:0] cmd_word(input logic [spi_pkg::SEL_W-1:0] sel,
                                             input logic [spi_pkg::DATA_W-1:0] tx);
        spi_pkg::spi_cmd_t c;
        c.sel = sel;
        c.tx  = tx;
        return {{(32 - CMD_W){1'b0}}, c};
    endfunction

    task automatic read_status(output logic [31:0] st);
        logic err;
        apb_read(spi_pkg::REG_STATUS, st, err);
    endtask

    task automatic wait_status(input logic [31:0] mask, input logic [31:0] value);
        logic [31:0] st;
        read_status(st);
        while ((st & mask) != value) read_status(st);
    endtask

    // Reads results while the command FIFO is full so that it never deadlocks.
    task automatic send_cmd(input logic [spi_pkg::SEL_W-1:0] sel,
                            input logic [spi_pkg::DATA_W-1:0] tx);
        logic [31:0] st;
        logic [31:0] rdata;
        logic        err;
        logic        sent;
        sent = 1'b0;
        while (!sent) begin
            read_status(st);
            if (!st[spi_pkg::ST_CMD_FULL]) begin
                apb_write(spi_pkg::REG_TXCMD, cmd_word(sel, tx), err);
                sent = 1'b1;
            end else if (!st[spi_pkg::ST_RX_EMPTY]) begin
                apb_read(spi_pkg::REG_RXDATA, rdata, err);
            end
        end
    endtask

    // Two idle status reads in a row rule out a push still in flight.
    task automatic drain_rx();
        logic [31:0] st;
        logic [31:0] rdata;
        logic        err;
        int          idle_reads;
        idle_reads = 0;
        while (idle_reads < 2) begin
            read_status(st);
            if (!st[spi_pkg::ST_RX_EMPTY]) begin
                apb_read(spi_pkg::REG_RXDATA, rdata, err);
                idle_reads = 0;
            end else if (st[spi_pkg::ST_CMD_EMPTY] && !st[spi_pkg::ST_BUSY]) begin
                idle_reads++;
            end else begin
                idle_reads = 0;
            end
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] st;
        logic [31:0] rdata;
        logic        err;
        int          other_total;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        read_status(st);    // Reset state.

        for (int s = 0; s < spi_pkg::SLAVE_COUNT; s++) begin
            send_cmd(spi_pkg::SEL_W'(s), 8'($urandom));
            wait_status(32'(1) << spi_pkg::ST_RX_EMPTY, '0);
            apb_read(spi_pkg::REG_RXDATA, rdata, err);
        end

        for (int i = 0; i < 8; i++) begin    // Surplus writes hit a full command FIFO.
            apb_write(spi_pkg::REG_TXCMD,
                      cmd_word(spi_pkg::SEL_W'(i % spi_pkg::SLAVE_COUNT), 8'($urandom)), err);
        end
        drain_rx();

        apb_read(spi_pkg::REG_RXDATA, rdata, err);

        for (int i = 0; i < RX_DEPTH + 2; i++) begin
            send_cmd(spi_pkg::SEL_W'($urandom % spi_pkg::SLAVE_COUNT), 8'($urandom));
        end
        wait_status((32'(1) << spi_pkg::ST_RX_FULL) | (32'(1) << spi_pkg::ST_CMD_EMPTY),
                    32'(1) << spi_pkg::ST_RX_FULL);
        drain_rx();

        for (int i = 0; i < 40; i++) begin
            send_cmd(spi_pkg::SEL_W'($urandom % spi_pkg::SLAVE_COUNT), 8'($urandom));
            if ($urandom % 3 == 0) begin
                read_status(st);
                if (!st[spi_pkg::ST_RX_EMPTY]) apb_read(spi_pkg::REG_RXDATA, rdata, err);
            end
        end
        drain_rx();

        repeat (4) @(posedge clk);
        other_total = other_count;
        if (outstanding != 0) begin
            other_total++;
            $display("%0d expected words were never read back", outstanding);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_total);
        if (mismatch_count == 0 && other_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
